//--- project.f
+incdir+common
common/lsu_pkg.sv
lsu/access_decode.sv
lsu/mem_access.sv
lsu/load_result.sv
design/lsu_top.sv
dv/tb_data_mem.sv
dv/lsu_tb.sv

//--- dv/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
import lsu_pkg::*;
();

    typedef struct packed {
        mem_op_t     op;
        mem_funct3_t funct3;
        word_t       addr;
        word_t       sdata;
        word_t       exp_data;
        logic        exp_mis;
        byte_mask_t  exp_mbe;
    } row_t;

    localparam int clk_period   = 10;
    localparam int reset_cycles = 8;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    mem_req_t   req;
    logic       ready;
    logic       data_read;
    logic       data_write;
    word_t      data_mem_address;
    byte_mask_t data_mbe;
    word_t      data_mem_wdata;
    word_t      data_mem_rdata;
    logic       data_mem_resp;
    logic       done;
    logic       misaligned;
    logic       load_is_valid;
    word_t      load_data;

    row_t rows[$];
    int   done_q[$];     // accepted rows awaiting done
    int   mem_q[$];      // accepted aligned rows awaiting the memory
    bit   row_bad [0:63];
    bit   table_ready;
    int   err_count;
    int   done_count;
    int   pass_count;
    int   fail_count;

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    lsu_top uut (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_valid        (req_valid),
        .req              (req),
        .ready            (ready),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_mem_address (data_mem_address),
        .data_mbe         (data_mbe),
        .data_mem_wdata   (data_mem_wdata),
        .data_mem_rdata   (data_mem_rdata),
        .data_mem_resp    (data_mem_resp),
        .done             (done),
        .misaligned       (misaligned),
        .load_is_valid    (load_is_valid),
        .load_data        (load_data)
    );

    tb_data_mem mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_read  (data_read),
        .data_write (data_write),
        .address    (data_mem_address),
        .mbe        (data_mbe),
        .wdata      (data_mem_wdata),
        .rdata      (data_mem_rdata),
        .resp       (data_mem_resp)
    );

    task automatic check_value(input int row, input word_t actual, input word_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: row %0d %s is %h, expected %h",
                     $time, row, what, actual, expected);
            err_count++;
            if (row >= 0) begin
                row_bad[row] = 1'b1;
            end
        end
    endtask

    function automatic void add_row(input mem_op_t op, input mem_funct3_t funct3,
                                    input word_t addr, input word_t sdata, input word_t exp_data,
                                    input logic exp_mis, input byte_mask_t exp_mbe);
        row_t r;
        r.op       = op;
        r.funct3   = funct3;
        r.addr     = addr;
        r.sdata    = sdata;
        r.exp_data = exp_data;
        r.exp_mis  = exp_mis;
        r.exp_mbe  = exp_mbe;
        rows.push_back(r);
    endfunction

    // store data moved up to its byte offset, lanes outside the mask cleared
    function automatic word_t placed_store_data(input row_t r);
        word_t shifted;
        word_t keep;
        shifted = r.sdata << (8 * r.addr[1:0]);
        keep    = '0;
        for (int i = 0; i < 4; i++) begin
            if (r.exp_mbe[i]) begin
                keep[i*8 +: 8] = 8'hff;
            end
        end
        return shifted & keep;
    endfunction

    // strobe, lane mask and stall while an aligned access is open
    always @(posedge clk) begin : strobe_watch
        int idx;
        if (rst_n && (data_read || data_write)) begin
            if (mem_q.size() == 0) begin
                $display("memory strobe at %0t ns with no aligned access outstanding", $time);
                err_count++;
            end else begin
                idx = mem_q[0];
                check_value(idx, data_mem_address, {rows[idx].addr[31:2], 2'b00}, "address");
                check_value(idx, data_mbe, rows[idx].exp_mbe, "data_mbe");
                check_value(idx, data_read, rows[idx].op == mem_op_load, "data_read");
                check_value(idx, data_write, rows[idx].op == mem_op_store, "data_write");
                if (rows[idx].op == mem_op_store) begin
                    check_value(idx, data_mem_wdata, placed_store_data(rows[idx]),
                                "data_mem_wdata");
                end
                if (!data_mem_resp) begin
                    check_value(idx, ready, 1'b0, "ready while waiting");
                end else begin
                    void'(mem_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin : done_watch
        int idx;
        if (rst_n && done) begin
            if (done_q.size() == 0) begin
                $display("done pulse at %0t ns with no request outstanding", $time);
                err_count++;
            end else begin
                idx = done_q.pop_front();     // oldest accepted row
                check_value(idx, load_data, rows[idx].exp_data, "load_data");
                check_value(idx, misaligned, rows[idx].exp_mis, "misaligned");
                check_value(idx, load_is_valid,
                            rows[idx].op == mem_op_load && !rows[idx].exp_mis, "load_is_valid");
                if (row_bad[idx]) begin
                    fail_count++;
                end else begin
                    pass_count++;
                end
                $display("row %2d %s at %h: %s", idx,
                         rows[idx].op == mem_op_load ? "load " : "store",
                         rows[idx].addr, row_bad[idx] ? "mismatch" : "ok");
                done_count++;
            end
        end
    end

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        err_count = 0;
        add_row(mem_op_store, lw,  32'h00, 32'h12345678, 32'h00000000, 1'b0, 4'b1111);
        add_row(mem_op_load,  lw,  32'h00, 32'h00000000, 32'h12345678, 1'b0, 4'b1111);
        add_row(mem_op_store, lb,  32'h04, 32'haaaaaa11, 32'h00000000, 1'b0, 4'b0001);
        add_row(mem_op_store, lb,  32'h05, 32'h00000022, 32'h00000000, 1'b0, 4'b0010);
        add_row(mem_op_load,  lw,  32'h04, 32'h00000000, 32'h87862211, 1'b0, 4'b1111);
        add_row(mem_op_store, lb,  32'h06, 32'h00000033, 32'h00000000, 1'b0, 4'b0100);
        add_row(mem_op_store, lb,  32'h07, 32'h00000044, 32'h00000000, 1'b0, 4'b1000);
        add_row(mem_op_load,  lw,  32'h04, 32'h00000000, 32'h44332211, 1'b0, 4'b1111);
        add_row(mem_op_store, lh,  32'h08, 32'hffff5566, 32'h00000000, 1'b0, 4'b0011);
        add_row(mem_op_load,  lw,  32'h08, 32'h00000000, 32'h8b8a5566, 1'b0, 4'b1111);
        add_row(mem_op_store, lh,  32'h0a, 32'h00007788, 32'h00000000, 1'b0, 4'b1100);
        add_row(mem_op_load,  lw,  32'h08, 32'h00000000, 32'h77885566, 1'b0, 4'b1111);
        add_row(mem_op_load,  lb,  32'h0c, 32'h00000000, 32'hffffff8c, 1'b0, 4'b0001);
        add_row(mem_op_load,  lb,  32'h0d, 32'h00000000, 32'hffffff8d, 1'b0, 4'b0010);
        add_row(mem_op_load,  lb,  32'h0e, 32'h00000000, 32'hffffff8e, 1'b0, 4'b0100);
        add_row(mem_op_load,  lb,  32'h0f, 32'h00000000, 32'hffffff8f, 1'b0, 4'b1000);
        add_row(mem_op_load,  lbu, 32'h0c, 32'h00000000, 32'h0000008c, 1'b0, 4'b0001);
        add_row(mem_op_load,  lbu, 32'h0d, 32'h00000000, 32'h0000008d, 1'b0, 4'b0010);
        add_row(mem_op_load,  lbu, 32'h0e, 32'h00000000, 32'h0000008e, 1'b0, 4'b0100);
        add_row(mem_op_load,  lbu, 32'h0f, 32'h00000000, 32'h0000008f, 1'b0, 4'b1000);
        add_row(mem_op_load,  lh,  32'h0c, 32'h00000000, 32'hffff8d8c, 1'b0, 4'b0011);
        add_row(mem_op_load,  lh,  32'h0e, 32'h00000000, 32'hffff8f8e, 1'b0, 4'b1100);
        add_row(mem_op_load,  lhu, 32'h0c, 32'h00000000, 32'h00008d8c, 1'b0, 4'b0011);
        add_row(mem_op_load,  lhu, 32'h0e, 32'h00000000, 32'h00008f8e, 1'b0, 4'b1100);
        add_row(mem_op_load,  lh,  32'h0a, 32'h00000000, 32'h00007788, 1'b0, 4'b1100);
        add_row(mem_op_load,  lb,  32'h05, 32'h00000000, 32'h00000022, 1'b0, 4'b0010);
        add_row(mem_op_load,  lh,  32'h11, 32'h00000000, 32'h00000000, 1'b1, 4'b0000);
        add_row(mem_op_load,  lw,  32'h12, 32'h00000000, 32'h00000000, 1'b1, 4'b0000);
        add_row(mem_op_store, lh,  32'h13, 32'h0000dead, 32'h00000000, 1'b1, 4'b0000);
        add_row(mem_op_store, lw,  32'h11, 32'hdeadbeef, 32'h00000000, 1'b1, 4'b0000);
        add_row(mem_op_load,  lhu, 32'h13, 32'h00000000, 32'h00000000, 1'b1, 4'b0000);
        add_row(mem_op_load,  lw,  32'h10, 32'h00000000, 32'h93929190, 1'b0, 4'b1111);
        add_row(mem_op_load,  lw,  32'h3c, 32'h00000000, 32'hbfbebdbc, 1'b0, 4'b1111);
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        check_value(-1, ready, 1'b1, "ready after reset");
        check_value(-1, data_read, 1'b0, "data_read after reset");
        check_value(-1, data_write, 1'b0, "data_write after reset");
        check_value(-1, done, 1'b0, "done after reset");
        check_value(-1, misaligned, 1'b0, "misaligned after reset");
        check_value(-1, load_is_valid, 1'b0, "load_is_valid after reset");

        for (int i = 0; i < rows.size(); i++) begin
            #1;
            req_valid      = 1'b1;
            req.op         = rows[i].op;
            req.funct3     = rows[i].funct3;
            req.address    = rows[i].addr;
            req.store_data = rows[i].sdata;
            @(posedge clk);
            while (!ready) @(posedge clk);     // held through the stall
            done_q.push_back(i);
            if (!rows[i].exp_mis) begin
                mem_q.push_back(i);
            end
        end
        #1;
        req_valid = 1'b0;
        req       = '0;

        wait (done_count == rows.size());
        repeat (4) @(posedge clk);
        check_value(-1, mem_q.size(), 0, "memory accesses left open");
        $display("rows: %0d passed, %0d failed, %0d errors", pass_count, fail_count, err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // ten cycles per row is well above the worst wait state
    initial begin
        wait (table_ready);
        #((rows.size() * 10 + reset_cycles + 4) * clk_period);
        $display("timeout: not every request finished within the time allowed");
        $display("sim failed");
        $finish;
    end

endmodule : lsu_tb

`default_nettype wire

//--- dv/tb_data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_data_mem
import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       data_read,
    input  logic       data_write,
    input  word_t      address,
    input  byte_mask_t mbe,
    input  word_t      wdata,
    output word_t      rdata,
    output logic       resp
);

    word_t       mem [0:15];
    logic [3:0]  idx;
    logic [31:0] lfsr;
    logic [31:0] step1;
    logic [31:0] step2;
    logic        busy;
    logic [1:0]  wait_left;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign idx   = address[5:2];
    assign step1 = lfsr_step(lfsr);
    assign step2 = lfsr_step(step1);

    // byte n holds n + 8'h80
    initial begin
        for (int w = 0; w < 16; w++) begin
            for (int b = 0; b < 4; b++) begin
                mem[w][b*8 +: 8] = 8'((w * 4) + b + 8'h80);
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr      <= 32'hac7;
            busy      <= 1'b0;
            wait_left <= 2'd0;
            resp      <= 1'b0;
            rdata     <= '0;
        end else if (resp) begin
            resp <= 1'b0;     // strobe still shows the finished access
        end else if (busy) begin
            if (wait_left == 2'd0) begin
                busy  <= 1'b0;
                resp  <= 1'b1;
                rdata <= mem[idx];
                for (int i = 0; i < 4; i++) begin
                    if (data_write && mbe[i]) begin
                        mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
                    end
                end
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end else if (data_read || data_write) begin
            busy      <= 1'b1;
            wait_left <= {step1[0], step2[0]};     // two lfsr bits
            lfsr      <= step2;
        end
    end

endmodule : tb_data_mem

`default_nettype wire

//--- design/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  mem_req_t   req,
    output logic       ready,

    // data memory
    output logic       data_read,
    output logic       data_write,
    output word_t      data_mem_address,
    output byte_mask_t data_mbe,
    output word_t      data_mem_wdata,
    input  word_t      data_mem_rdata,
    input  logic       data_mem_resp,

    output logic       done,
    output logic       misaligned,
    output logic       load_is_valid,
    output word_t      load_data
);

    mem_access_t access;
    mem_done_t   done_rec;
    logic        advance;

    assign ready = advance;     // stall seen by the requester

    access_decode access_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .advance   (advance),
        .access    (access)
    );

    mem_access mem_access (
        .clk              (clk),
        .rst_n            (rst_n),
        .access           (access),
        .data_mem_rdata   (data_mem_rdata),
        .data_mem_resp    (data_mem_resp),
        .advance          (advance),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_mem_address (data_mem_address),
        .data_mbe         (data_mbe),
        .data_mem_wdata   (data_mem_wdata),
        .done_rec         (done_rec)
    );

    load_result load_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .done_rec      (done_rec),
        .done          (done),
        .misaligned    (misaligned),
        .load_is_valid (load_is_valid),
        .load_data     (load_data)
    );

endmodule : lsu_top

`default_nettype wire

//--- lsu/load_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module load_result
import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  mem_done_t done_rec,
    output logic      done,
    output logic      misaligned,
    output logic      load_is_valid,
    output word_t     load_data
);

    logic  is_load;
    byte_t sel_byte;
    half_t sel_half;
    word_t ext_data;

    assign is_load = done_rec.valid && !done_rec.misaligned &&
                     (done_rec.op == mem_op_load);

    // lane select driven by the mask
    always_comb begin
        sel_byte = '0;
        for (int i = 0; i < `LSU_MASK_W; i++) begin
            if (done_rec.mask[i]) begin
                sel_byte = done_rec.rdata[i*`LSU_BYTE_W +: `LSU_BYTE_W];
            end
        end
        if (done_rec.mask[`LSU_MASK_W-1]) begin
            sel_half = done_rec.rdata[`LSU_XLEN-1 -: `LSU_HALF_W];     // upper half
        end else begin
            sel_half = done_rec.rdata[`LSU_HALF_W-1:0];
        end
    end

    always_comb begin
        case (done_rec.funct3)
            lb:      ext_data = {{(`LSU_XLEN-`LSU_BYTE_W){sel_byte[`LSU_BYTE_W-1]}}, sel_byte};
            lbu:     ext_data = word_t'(sel_byte);
            lh:      ext_data = {{(`LSU_XLEN-`LSU_HALF_W){sel_half[`LSU_HALF_W-1]}}, sel_half};
            lhu:     ext_data = word_t'(sel_half);
            default: ext_data = done_rec.rdata;     // lw
        endcase
    end

    // result register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done          <= 1'b0;
            misaligned    <= 1'b0;
            load_is_valid <= 1'b0;
            load_data     <= '0;
        end else begin
            done          <= done_rec.valid;
            misaligned    <= done_rec.valid && done_rec.misaligned;
            load_is_valid <= is_load;
            load_data     <= is_load ? ext_data : '0;
        end
    end

    a_byte_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        is_load && (done_rec.funct3 == lb || done_rec.funct3 == lbu)
            |-> $onehot(done_rec.mask))
        else $error("byte load without a single lane");

endmodule : load_result

`default_nettype wire

//--- lsu/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module mem_access
import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  mem_access_t access,
    input  word_t       data_mem_rdata,
    input  logic        data_mem_resp,
    output logic        advance,
    output logic        data_read,
    output logic        data_write,
    output word_t       data_mem_address,
    output byte_mask_t  data_mbe,
    output word_t       data_mem_wdata,
    output mem_done_t   done_rec
);

    logic aligned_valid;
    logic complete;

    assign aligned_valid = access.valid && !access.misaligned;

    // strobes stay up until the response arrives
    assign data_read        = aligned_valid && (access.op == mem_op_load);
    assign data_write       = aligned_valid && (access.op == mem_op_store);
    assign data_mem_address = access.word_addr;
    assign data_mbe         = access.mask;
    assign data_mem_wdata   = access.wdata;

    // misaligned accesses finish without touching memory
    assign complete = access.valid && (access.misaligned || data_mem_resp);
    assign advance  = !access.valid || complete;

    // completion record
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_rec <= '0;
        end else begin
            done_rec.valid <= complete;     // single cycle per access
            if (complete) begin
                done_rec.op         <= access.op;
                done_rec.funct3     <= access.funct3;
                done_rec.mask       <= access.mask;
                done_rec.rdata      <= data_mem_rdata;
                done_rec.misaligned <= access.misaligned;
            end
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_read && data_write))
        else $error("data_read and data_write high together");

    // an open access keeps its strobe, address and mask until memory answers
    a_addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        (data_read || data_write) && !data_mem_resp |=>
            (data_read || data_write) && $stable(data_mem_address) && $stable(data_mbe))
        else $error("access changed before data_mem_resp");

endmodule : mem_access

`default_nettype wire

//--- lsu/access_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module access_decode
import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  mem_req_t    req,
    input  logic        advance,
    output mem_access_t access
);

    logic [`LSU_WORD_LSB-1:0] offset;
    byte_mask_t               mask;
    logic                     misaligned;
    word_t                    lanes;
    word_t                    wdata;
    mem_access_t              access_next;

    assign offset = req.address[`LSU_WORD_LSB-1:0];

    // mask from width and offset
    always_comb begin
        mask       = `LSU_MASK_NONE;
        misaligned = 1'b0;
        case (req.funct3)
            lb, lbu: begin
                mask = byte_mask_t'(1) << offset;
            end
            lh, lhu: begin
                if (offset[0]) begin
                    misaligned = 1'b1;     // odd halfword
                end else begin
                    mask = byte_mask_t'(2'b11) << offset;
                end
            end
            lw: begin
                if (offset != '0) begin
                    misaligned = 1'b1;
                end else begin
                    mask = `LSU_MASK_ALL;
                end
            end
            default: misaligned = 1'b1;    // unknown width, no request made
        endcase
    end

    // replicate the low part, then keep only the enabled lanes
    always_comb begin
        case (req.funct3)
            lb, lbu: lanes = {`LSU_MASK_W{req.store_data[`LSU_BYTE_W-1:0]}};
            lh, lhu: lanes = {2{req.store_data[`LSU_HALF_W-1:0]}};
            default: lanes = req.store_data;
        endcase
        wdata = '0;
        for (int i = 0; i < `LSU_MASK_W; i++) begin
            if (req.op == mem_op_store && mask[i]) begin
                wdata[i*`LSU_BYTE_W +: `LSU_BYTE_W] = lanes[i*`LSU_BYTE_W +: `LSU_BYTE_W];
            end
        end
    end

    always_comb begin
        access_next.valid      = req_valid;
        access_next.op         = req.op;
        access_next.funct3     = req.funct3;
        access_next.word_addr  = {req.address[`LSU_XLEN-1:`LSU_WORD_LSB],
                                  {`LSU_WORD_LSB{1'b0}}};
        access_next.mask       = mask;
        access_next.wdata      = wdata;
        access_next.misaligned = misaligned;
    end

    // request stage register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            access <= '0;
        end else if (advance) begin
            access <= access_next;     // bubble when req_valid is low
        end
    end

    a_mask_vs_misaligned: assert property (@(posedge clk) disable iff (!rst_n)
        access.valid |-> ((access.mask == `LSU_MASK_NONE) == access.misaligned))
        else $error("stage mask disagrees with misaligned flag");

endmodule : access_decode

`default_nettype wire

//--- common/lsu_pkg.sv
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   word_t;      // data or address word
    typedef logic [`LSU_HALF_W-1:0] half_t;
    typedef logic [`LSU_BYTE_W-1:0] byte_t;
    typedef logic [`LSU_MASK_W-1:0] byte_mask_t; // one bit per lane

    typedef enum logic {
        mem_op_load,
        mem_op_store
    } mem_op_t;

    // stores reuse lb/lh/lw as sb/sh/sw
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } mem_funct3_t;

    typedef struct packed {
        mem_op_t     op;
        mem_funct3_t funct3;
        word_t       address;    // full alu result
        word_t       store_data;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        mem_op_t     op;
        mem_funct3_t funct3;
        word_t       word_addr;  // low bits cleared
        byte_mask_t  mask;
        word_t       wdata;      // already in its lanes
        logic        misaligned;
    } mem_access_t;

    typedef struct packed {
        logic        valid;
        mem_op_t     op;
        mem_funct3_t funct3;
        byte_mask_t  mask;
        word_t       rdata;
        logic        misaligned;
    } mem_done_t;

endpackage : lsu_pkg

`default_nettype wire

//--- common/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// RV32I data bus geometry
`define LSU_XLEN     32
`define LSU_MASK_W   4
`define LSU_BYTE_W   8
`define LSU_HALF_W   16
`define LSU_WORD_LSB 2

// byte enable patterns
`define LSU_MASK_NONE 4'b0000
`define LSU_MASK_ALL  4'b1111

`endif
